// File: logic/sched_pkg.sv
// Scheduler package with widths, state and command codes, and age helpers
package sched_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////
  localparam int NUM_BANKS = 4;
  localparam int BANK_W    = 2;
  localparam int STATE_W   = 4;
  localparam int ADDR_W    = 14;
  localparam int AGE_W     = 8;
  localparam int CMD_W     = 3;
  localparam int CLASS_W   = 4;

  //////////////////////////////////////////////////
  // Bank controller state codes
  //////////////////////////////////////////////////
  localparam logic [STATE_W-1:0] ST_IDLE        = 4'd0;
  localparam logic [STATE_W-1:0] ST_ACT_CHECK   = 4'd1;
  localparam logic [STATE_W-1:0] ST_ACTIVE      = 4'd2;
  localparam logic [STATE_W-1:0] ST_WRITE_CHECK = 4'd3;
  localparam logic [STATE_W-1:0] ST_WRITE       = 4'd4;
  localparam logic [STATE_W-1:0] ST_READ_CHECK  = 4'd5;
  localparam logic [STATE_W-1:0] ST_READ        = 4'd6;
  localparam logic [STATE_W-1:0] ST_PRE_CHECK   = 4'd7;
  localparam logic [STATE_W-1:0] ST_PRE         = 4'd8;
  localparam logic [STATE_W-1:0] ST_ACT_STANDBY = 4'd9;

  // Issued DRAM commands
  localparam logic [CMD_W-1:0] CMD_NOP       = 3'd0;
  localparam logic [CMD_W-1:0] CMD_ACTIVE    = 3'd1;
  localparam logic [CMD_W-1:0] CMD_READ      = 3'd2;
  localparam logic [CMD_W-1:0] CMD_WRITE     = 3'd3;
  localparam logic [CMD_W-1:0] CMD_PRECHARGE = 3'd4;

  // Bit positions in the one-hot class vector
  localparam int CLS_ACT   = 3;
  localparam int CLS_WRITE = 2;
  localparam int CLS_READ  = 1;
  localparam int CLS_PRE   = 0;

  localparam int PRE_AGE_LIMIT = 16;  // Precharge turns urgent above this

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // True when age beats all three others, ties give false
  function automatic logic age_is_max(
    input logic [AGE_W-1:0] age,
    input logic [AGE_W-1:0] other_a,
    input logic [AGE_W-1:0] other_b,
    input logic [AGE_W-1:0] other_c
  );
    return (age > other_a) && (age > other_b) && (age > other_c);
  endfunction

  // One-hot kind of a bank state, zero when it has none
  function automatic logic [CLASS_W-1:0] state_kind(input logic [STATE_W-1:0] st);
    logic [CLASS_W-1:0] kind;
    kind = '0;
    case (st)
      ST_ACT_CHECK, ST_ACTIVE:    kind[CLS_ACT]   = 1'b1;
      ST_WRITE_CHECK, ST_WRITE:   kind[CLS_WRITE] = 1'b1;
      ST_READ_CHECK, ST_READ:     kind[CLS_READ]  = 1'b1;
      ST_PRE_CHECK, ST_PRE:       kind[CLS_PRE]   = 1'b1;
      ST_IDLE, ST_ACT_STANDBY:    kind = '0;  // Not waiting on anything
      default:                    kind = '0;
    endcase
    return kind;
  endfunction

endpackage

// File: logic/bank_age_counters.sv
// Per-bank waiting-age counters, running while a bank sits in a check or command state
`timescale 1ns/1ns

module bank_age_counters
  import sched_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic [STATE_W-1:0] ba_state [NUM_BANKS],
  output logic [AGE_W-1:0]   ba_age   [NUM_BANKS]
);

  logic bank_waiting [NUM_BANKS];

  always_comb begin
    for (int i = 0; i < NUM_BANKS; i++) begin
      bank_waiting[i] = |state_kind(ba_state[i]);
    end
  end

  //////////////////////////////////////////////////
  // Age registers
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_BANKS; i++) begin
        ba_age[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_BANKS; i++) begin
        if (bank_waiting[i]) begin
          ba_age[i] <= ba_age[i] + 1'b1;  // Wraps at the top
        end else begin
          ba_age[i] <= '0;                // Restart once the bank leaves
        end
      end
    end
  end

endmodule

// File: logic/cmd_authorizer.sv
// Command class authorizer, picks one class among the pending ones each cycle
`timescale 1ns/1ns

module cmd_authorizer
  import sched_pkg::*;
(
  input  logic [STATE_W-1:0] ba_state [NUM_BANKS],
  input  logic [AGE_W-1:0]   ba_age   [NUM_BANKS],
  output logic [CLASS_W-1:0] cls_grant
);

  logic [CLASS_W-1:0] bank_kind [NUM_BANKS];
  logic [CLASS_W-1:0] pending;
  logic [BANK_W-1:0]  oldest;
  logic [CLASS_W-1:0] oldest_kind;
  logic               pre_urgent;
  logic [CLASS_W-1:0] rest;

  //////////////////////////////////////////////////
  // Pending classes and precharge urgency
  //////////////////////////////////////////////////
  always_comb begin
    pending    = '0;
    pre_urgent = 1'b0;
    for (int i = 0; i < NUM_BANKS; i++) begin
      bank_kind[i] = state_kind(ba_state[i]);
      pending      = pending | bank_kind[i];
      // Raw ages here, the masked ones depend on the grant
      if (bank_kind[i][CLS_PRE] && (ba_age[i] > AGE_W'(PRE_AGE_LIMIT))) begin
        pre_urgent = 1'b1;
      end
    end
  end

  // Oldest bank, bank 0 unless one age is strictly greatest
  always_comb begin
    oldest = '0;
    for (int i = 0; i < NUM_BANKS; i++) begin
      if (age_is_max(ba_age[i],
                     ba_age[(i + 1) % NUM_BANKS],
                     ba_age[(i + 2) % NUM_BANKS],
                     ba_age[(i + 3) % NUM_BANKS])) begin
        oldest = BANK_W'(i);
      end
    end
  end

  assign oldest_kind = bank_kind[oldest];

  //////////////////////////////////////////////////
  // Class selection
  //////////////////////////////////////////////////
  always_comb begin
    cls_grant = '0;
    rest      = pending;
    if (pending == '0) begin
      cls_grant = '0;                       // Nothing to do
    end else if ((pending & (pending - 1'b1)) == '0) begin
      cls_grant = pending;                  // Lone class
    end else begin
      if (pending[CLS_PRE]) begin
        if (pending[CLS_ACT] || oldest_kind[CLS_PRE] || pre_urgent) begin
          cls_grant[CLS_PRE] = 1'b1;
        end
        rest[CLS_PRE] = 1'b0;
      end

      if (cls_grant == '0) begin
        if (rest[CLS_ACT] &&
            ((!rest[CLS_WRITE] && !rest[CLS_READ]) || oldest_kind[CLS_ACT])) begin
          cls_grant[CLS_ACT] = 1'b1;
        end else begin
          rest[CLS_ACT] = 1'b0;
          if (rest[CLS_WRITE] && rest[CLS_READ]) begin
            // Follow the oldest bank between write and read
            if (oldest_kind[CLS_WRITE]) begin
              cls_grant[CLS_WRITE] = 1'b1;
            end else begin
              cls_grant[CLS_READ] = 1'b1;
            end
          end else begin
            cls_grant = rest;               // Only one left by now
          end
        end
      end
    end
  end

endmodule

// File: logic/bank_arbiter.sv
// Bank arbiter, releases the oldest bank of the granted class and stalls the rest
`timescale 1ns/1ns

module bank_arbiter
  import sched_pkg::*;
(
  input  logic [STATE_W-1:0] ba_state [NUM_BANKS],
  input  logic [AGE_W-1:0]   ba_age   [NUM_BANKS],
  input  logic [CLASS_W-1:0] cls_grant,
  input  logic               isu_fifo_full,
  output logic               ba_stall [NUM_BANKS]
);

  logic [AGE_W-1:0] masked_age [NUM_BANKS];
  logic             any_pending;

  //////////////////////////////////////////////////
  // Age masking by granted class
  //////////////////////////////////////////////////
  always_comb begin
    any_pending = 1'b0;
    for (int i = 0; i < NUM_BANKS; i++) begin
      any_pending = any_pending | (|state_kind(ba_state[i]));
      if (cls_grant == '0) begin
        masked_age[i] = ba_age[i];          // No class, raw ages
      end else if ((state_kind(ba_state[i]) & cls_grant) != '0) begin
        masked_age[i] = ba_age[i];
      end else begin
        masked_age[i] = '0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Grant and stall
  //////////////////////////////////////////////////
  always_comb begin
    for (int i = 0; i < NUM_BANKS; i++) begin
      // A tie leaves no bank strictly greatest, so everyone stalls
      ba_stall[i] = isu_fifo_full || !any_pending ||
                    !age_is_max(masked_age[i],
                                masked_age[(i + 1) % NUM_BANKS],
                                masked_age[(i + 2) % NUM_BANKS],
                                masked_age[(i + 3) % NUM_BANKS]);
    end
  end

endmodule

// File: logic/issue_select.sv
// Issue path, forwards the lowest-index bank in a command state to the issue FIFO
`timescale 1ns/1ns

module issue_select
  import sched_pkg::*;
(
  input  logic [STATE_W-1:0] ba_state [NUM_BANKS],
  input  logic [ADDR_W-1:0]  ba_addr  [NUM_BANKS],
  output logic [CMD_W-1:0]   sch_cmd,
  output logic [ADDR_W-1:0]  sch_addr,
  output logic [BANK_W-1:0]  sch_bank,
  output logic               sch_issue
);

  // Command for a state, NOP when the bank is not in a command state
  function automatic logic [CMD_W-1:0] decode_cmd(input logic [STATE_W-1:0] st);
    logic [CMD_W-1:0] cmd;
    case (st)
      ST_ACTIVE: cmd = CMD_ACTIVE;
      ST_READ:   cmd = CMD_READ;
      ST_WRITE:  cmd = CMD_WRITE;
      ST_PRE:    cmd = CMD_PRECHARGE;
      default:   cmd = CMD_NOP;
    endcase
    return cmd;
  endfunction

  //////////////////////////////////////////////////
  // Priority scan, bank 0 first
  //////////////////////////////////////////////////
  always_comb begin
    sch_cmd   = CMD_NOP;
    sch_addr  = ba_addr[0];   // Bank 0 when idle
    sch_bank  = '0;
    sch_issue = 1'b0;
    // Walk downward so the lowest index is written last
    for (int i = NUM_BANKS - 1; i >= 0; i--) begin
      if (decode_cmd(ba_state[i]) != CMD_NOP) begin
        sch_cmd   = decode_cmd(ba_state[i]);
        sch_addr  = ba_addr[i];
        sch_bank  = BANK_W'(i);
        sch_issue = 1'b1;
      end
    end
  end

endmodule

// File: logic/cmd_scheduler.sv
// DRAM command scheduler top for four banks, class pick, bank grant and issue path
`timescale 1ns/1ns

module cmd_scheduler
  import sched_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic [STATE_W-1:0] ba_state [NUM_BANKS],
  input  logic [ADDR_W-1:0]  ba_addr  [NUM_BANKS],
  input  logic               isu_fifo_full,
  output logic               ba_stall [NUM_BANKS],
  output logic [CMD_W-1:0]   sch_cmd,
  output logic [ADDR_W-1:0]  sch_addr,
  output logic [BANK_W-1:0]  sch_bank,
  output logic               sch_issue
);

  logic [AGE_W-1:0]   ba_age [NUM_BANKS];
  logic [CLASS_W-1:0] cls_grant;

  //////////////////////////////////////////////////
  // Grant side
  //////////////////////////////////////////////////
  bank_age_counters i_bank_age_counters (
    .clk      (clk),
    .rst_n    (rst_n),
    .ba_state (ba_state),
    .ba_age   (ba_age)
  );

  cmd_authorizer i_cmd_authorizer (
    .ba_state  (ba_state),
    .ba_age    (ba_age),
    .cls_grant (cls_grant)
  );

  bank_arbiter i_bank_arbiter (
    .ba_state      (ba_state),
    .ba_age        (ba_age),
    .cls_grant     (cls_grant),
    .isu_fifo_full (isu_fifo_full),
    .ba_stall      (ba_stall)
  );

  //////////////////////////////////////////////////
  // Issue side
  //////////////////////////////////////////////////

  // Stalled banks hold their state, so FIFO full is not needed here
  issue_select i_issue_select (
    .ba_state  (ba_state),
    .ba_addr   (ba_addr),
    .sch_cmd   (sch_cmd),
    .sch_addr  (sch_addr),
    .sch_bank  (sch_bank),
    .sch_issue (sch_issue)
  );

endmodule

// File: tb/cmd_scheduler_props.sv
// Concurrent checks on the scheduler stall and issue outputs, bound to the top level
`timescale 1ns/1ns

module cmd_scheduler_props
  import sched_pkg::*;
(
  input logic               clk,
  input logic               rst_n,
  input logic [STATE_W-1:0] ba_state [NUM_BANKS],
  input logic               isu_fifo_full,
  input logic               ba_stall [NUM_BANKS],
  input logic [CMD_W-1:0]   sch_cmd,
  input logic               sch_issue
);

  logic [NUM_BANKS-1:0] released;   // Bit set for a bank with stall low
  logic                 all_idle;
  int                   fail_count = 0;

  always_comb begin
    all_idle = 1'b1;
    for (int i = 0; i < NUM_BANKS; i++) begin
      released[i] = !ba_stall[i];
      if (ba_state[i] != ST_IDLE) begin
        all_idle = 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Properties
  //////////////////////////////////////////////////
  a_single_release: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(released))
    else begin
      $error("More than one bank released, mask %b", released);
      fail_count++;
    end

  a_full_stalls_all: assert property (@(posedge clk) disable iff (!rst_n)
    isu_fifo_full |-> (released == '0))
    else begin
      $error("Bank released while the issue FIFO is full");
      fail_count++;
    end

  a_nop_when_no_issue: assert property (@(posedge clk) disable iff (!rst_n)
    !sch_issue |-> (sch_cmd == CMD_NOP))
    else begin
      $error("Command 0x%h without issue", sch_cmd);
      fail_count++;
    end

  // Ages are all zero one cycle after release, so nothing can win yet
  a_idle_after_reset: assert property (@(posedge clk)
    ($rose(rst_n) && all_idle) |=> (released == '0))
    else begin
      $error("Bank released right after reset with all banks idle");
      fail_count++;
    end

endmodule

bind cmd_scheduler cmd_scheduler_props i_props (
  .clk           (clk),
  .rst_n         (rst_n),
  .ba_state      (ba_state),
  .isu_fifo_full (isu_fifo_full),
  .ba_stall      (ba_stall),
  .sch_cmd       (sch_cmd),
  .sch_issue     (sch_issue)
);

// File: tb/cmd_scheduler_tb.sv
// Testbench for the DRAM command scheduler, table-driven stall, class and issue checks
`timescale 1ns/1ns

module cmd_scheduler_tb
  import sched_pkg::*;
;

  localparam int          CLK_PERIOD   = 40;
  localparam int          RESET_CYCLES = 4;
  localparam int          MARGIN       = 20;
  localparam logic [31:0] SEED         = 32'hfdc6_fe82;

  logic               clk;
  logic               rst_n;
  logic [STATE_W-1:0] ba_state [NUM_BANKS];
  logic [ADDR_W-1:0]  ba_addr  [NUM_BANKS];
  logic               isu_fifo_full;
  logic               ba_stall [NUM_BANKS];
  logic [CMD_W-1:0]   sch_cmd;
  logic [ADDR_W-1:0]  sch_addr;
  logic [BANK_W-1:0]  sch_bank;
  logic               sch_issue;

  // Stimulus and expected values, one entry per row
  logic [NUM_BANKS*STATE_W-1:0] row_states [$];
  logic                         row_full   [$];
  int                           row_hold   [$];
  logic [NUM_BANKS-1:0]         row_stall  [$];  // Bit i is bank i
  logic [CMD_W-1:0]             row_cmd    [$];
  logic [BANK_W-1:0]            row_bank   [$];  // Also picks the expected address
  logic                         row_issue  [$];

  int cur_row;
  int cycle_count;
  int cycle_limit;

  cmd_scheduler i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .ba_state      (ba_state),
    .ba_addr       (ba_addr),
    .isu_fifo_full (isu_fifo_full),
    .ba_stall      (ba_stall),
    .sch_cmd       (sch_cmd),
    .sch_addr      (sch_addr),
    .sch_bank      (sch_bank),
    .sch_issue     (sch_issue)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Failure reporting and compare tasks
  //////////////////////////////////////////////////
  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_stall(input logic [NUM_BANKS-1:0] expected,
                             input logic [NUM_BANKS-1:0] actual);
    if (actual !== expected) begin
      fail_run($sformatf("[ERROR] ba_stall expected 0x%h got 0x%h (row %0d)",
                         expected, actual, cur_row));
    end
  endtask

  task automatic check_cmd(input logic [CMD_W-1:0] expected, input logic [CMD_W-1:0] actual);
    if (actual !== expected) begin
      fail_run($sformatf("[ERROR] sch_cmd expected 0x%h got 0x%h (row %0d)",
                         expected, actual, cur_row));
    end
  endtask

  task automatic check_addr(input logic [ADDR_W-1:0] expected, input logic [ADDR_W-1:0] actual);
    if (actual !== expected) begin
      fail_run($sformatf("[ERROR] sch_addr expected 0x%h got 0x%h (row %0d)",
                         expected, actual, cur_row));
    end
  endtask

  task automatic check_bank(input logic [BANK_W-1:0] expected, input logic [BANK_W-1:0] actual);
    if (actual !== expected) begin
      fail_run($sformatf("[ERROR] sch_bank expected 0x%h got 0x%h (row %0d)",
                         expected, actual, cur_row));
    end
  endtask

  task automatic check_issue(input logic expected, input logic actual);
    if (actual !== expected) begin
      fail_run($sformatf("[ERROR] sch_issue expected 0x%h got 0x%h (row %0d)",
                         expected, actual, cur_row));
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////
  task automatic add_row(input logic [STATE_W-1:0] s0, input logic [STATE_W-1:0] s1,
                         input logic [STATE_W-1:0] s2, input logic [STATE_W-1:0] s3,
                         input logic full, input int hold,
                         input logic [NUM_BANKS-1:0] stall, input logic [CMD_W-1:0] cmd,
                         input logic [BANK_W-1:0] bank, input logic issue);
    row_states.push_back({s3, s2, s1, s0});
    row_full.push_back(full);
    row_hold.push_back(hold);
    row_stall.push_back(stall);
    row_cmd.push_back(cmd);
    row_bank.push_back(bank);
    row_issue.push_back(issue);
  endtask

  // Columns: bank 0..3 states, fifo full, hold, stall, cmd, bank, issue
  task automatic build_table();
    add_row(ST_IDLE, ST_IDLE, ST_IDLE, ST_IDLE,
            1'b0, 2, 4'b1111, CMD_NOP, 2'd0, 1'b0);              // Idle after reset
    add_row(ST_IDLE, ST_IDLE, ST_READ, ST_IDLE,
            1'b0, 3, 4'b1011, CMD_READ, 2'd2, 1'b1);
    add_row(ST_IDLE, ST_IDLE, ST_IDLE, ST_IDLE,
            1'b0, 1, 4'b1111, CMD_NOP, 2'd0, 1'b0);
    add_row(ST_IDLE, ST_WRITE_CHECK, ST_IDLE, ST_IDLE,
            1'b0, 3, 4'b1101, CMD_NOP, 2'd0, 1'b0);
    add_row(ST_IDLE, ST_WRITE_CHECK, ST_IDLE, ST_WRITE_CHECK,
            1'b0, 2, 4'b1101, CMD_NOP, 2'd0, 1'b0);              // Ages 4 and 1
    add_row(ST_IDLE, ST_IDLE, ST_IDLE, ST_IDLE,
            1'b0, 1, 4'b1111, CMD_NOP, 2'd0, 1'b0);
    add_row(ST_WRITE_CHECK, ST_IDLE, ST_WRITE_CHECK, ST_IDLE,
            1'b0, 3, 4'b1111, CMD_NOP, 2'd0, 1'b0);              // Tied ages
    add_row(ST_WRITE_CHECK, ST_READ_CHECK, ST_IDLE, ST_IDLE,
            1'b0, 2, 4'b1110, CMD_NOP, 2'd0, 1'b0);              // Oldest is write
    add_row(ST_IDLE, ST_READ_CHECK, ST_IDLE, ST_WRITE,
            1'b0, 2, 4'b1101, CMD_WRITE, 2'd3, 1'b1);            // Oldest is read
    add_row(ST_IDLE, ST_ACT_STANDBY, ST_IDLE, ST_IDLE,
            1'b0, 1, 4'b1111, CMD_NOP, 2'd0, 1'b0);
    add_row(ST_ACTIVE, ST_IDLE, ST_IDLE, ST_IDLE,
            1'b0, 3, 4'b1110, CMD_ACTIVE, 2'd0, 1'b1);
    add_row(ST_ACT_CHECK, ST_PRE, ST_IDLE, ST_IDLE,
            1'b0, 2, 4'b1101, CMD_PRECHARGE, 2'd1, 1'b1);        // Precharge beats activate
    add_row(ST_IDLE, ST_IDLE, ST_IDLE, ST_IDLE,
            1'b0, 1, 4'b1111, CMD_NOP, 2'd0, 1'b0);
    add_row(ST_IDLE, ST_IDLE, ST_WRITE_CHECK, ST_IDLE,
            1'b0, 3, 4'b1011, CMD_NOP, 2'd0, 1'b0);
    add_row(ST_IDLE, ST_IDLE, ST_WRITE_CHECK, ST_PRE_CHECK,
            1'b0, 10, 4'b1011, CMD_NOP, 2'd0, 1'b0);
    add_row(ST_IDLE, ST_IDLE, ST_WRITE_CHECK, ST_PRE_CHECK,
            1'b0, 7, 4'b1011, CMD_NOP, 2'd0, 1'b0);              // Precharge age at 16
    add_row(ST_IDLE, ST_IDLE, ST_WRITE_CHECK, ST_PRE_CHECK,
            1'b0, 1, 4'b0111, CMD_NOP, 2'd0, 1'b0);              // Now 17, urgent
    // Back-pressure, issue path keeps going
    add_row(ST_IDLE, ST_READ, ST_WRITE_CHECK, ST_PRE,
            1'b1, 2, 4'b1111, CMD_READ, 2'd1, 1'b1);
    add_row(ST_IDLE, ST_READ, ST_WRITE_CHECK, ST_PRE,
            1'b0, 1, 4'b0111, CMD_READ, 2'd1, 1'b1);             // Grant on bank 3
    add_row(ST_IDLE, ST_IDLE, ST_IDLE, ST_IDLE,
            1'b0, 1, 4'b1111, CMD_NOP, 2'd0, 1'b0);
    add_row(ST_READ_CHECK, ST_IDLE, ST_IDLE, ST_IDLE,
            1'b0, 4, 4'b1110, CMD_NOP, 2'd0, 1'b0);
    add_row(ST_READ_CHECK, ST_IDLE, ST_IDLE, ST_READ_CHECK,
            1'b0, 2, 4'b1110, CMD_NOP, 2'd0, 1'b0);
    add_row(ST_IDLE, ST_IDLE, ST_IDLE, ST_READ_CHECK,
            1'b0, 1, 4'b0111, CMD_NOP, 2'd0, 1'b0);              // Bank 0 age restarts
    add_row(ST_READ, ST_IDLE, ST_IDLE, ST_READ_CHECK,
            1'b0, 2, 4'b0111, CMD_READ, 2'd0, 1'b1);
    add_row(ST_IDLE, ST_IDLE, ST_IDLE, ST_IDLE,
            1'b0, 2, 4'b1111, CMD_NOP, 2'd0, 1'b0);
  endtask

  task automatic apply_row(input int r);
    for (int i = 0; i < NUM_BANKS; i++) begin
      ba_state[i] = row_states[r][i*STATE_W +: STATE_W];
      ba_addr[i]  = ADDR_W'($urandom());
    end
    isu_fifo_full = row_full[r];
  endtask

  task automatic check_row(input int r);
    logic [NUM_BANKS-1:0] stall_now;
    for (int i = 0; i < NUM_BANKS; i++) begin
      stall_now[i] = ba_stall[i];
    end
    cur_row = r;
    check_stall(row_stall[r], stall_now);
    check_cmd(row_cmd[r], sch_cmd);
    check_addr(ba_addr[row_bank[r]], sch_addr);
    check_bank(row_bank[r], sch_bank);
    check_issue(row_issue[r], sch_issue);
  endtask

  //////////////////////////////////////////////////
  // Timeout
  //////////////////////////////////////////////////
  initial begin
    cycle_count = 0;
    @(posedge clk);
    while (cycle_count <= cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the stimulus table did not finish within %0d clock cycles", cycle_limit);
    fail_run("Run ended by the cycle limit");
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial begin
    void'($urandom(SEED));
    rst_n         = 1'b0;
    isu_fifo_full = 1'b0;
    cur_row       = -1;
    for (int i = 0; i < NUM_BANKS; i++) begin
      ba_state[i] = ST_IDLE;
      ba_addr[i]  = '0;
    end
    build_table();
    cycle_limit = RESET_CYCLES + MARGIN;
    foreach (row_hold[r]) begin
      cycle_limit += row_hold[r];
    end

    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    for (int r = 0; r < row_hold.size(); r++) begin
      @(negedge clk);
      apply_row(r);
      repeat (row_hold[r] - 1) @(negedge clk);
      #(CLK_PERIOD / 4);   // Last cycle of the hold, before the rising edge
      check_row(r);
    end

    if (i_dut.i_props.fail_count != 0) begin
      fail_run($sformatf("%0d concurrent assertion failures during the run",
                         i_dut.i_props.fail_count));
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

// File: compile.f
logic/sched_pkg.sv
logic/bank_age_counters.sv
logic/cmd_authorizer.sv
logic/bank_arbiter.sv
logic/issue_select.sv
logic/cmd_scheduler.sv
tb/cmd_scheduler_props.sv
tb/cmd_scheduler_tb.sv
